//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_mesh_monitor
FILELIST := mesh_monitor.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- console_arbiter.sv
`default_nettype none

// Round-robin merge of whole lines onto one console stream
module console_arbiter #(
  parameter int N_TILES = 4
) (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic [N_TILES-1:0]   line_ready_i,
  input  mesh_pkg::char_t      head_char_i [N_TILES],
  input  logic [N_TILES-1:0]   head_last_i,
  output logic [N_TILES-1:0]   pop_o,       // One-hot, head taken this cycle
  output logic                 con_valid_o,
  output logic [$clog2(N_TILES)-1:0] con_tile_o,
  output mesh_pkg::char_t      con_char_o,
  output logic                 con_last_o
);

  localparam int TILE_W = $clog2(N_TILES);

  mesh_pkg::arb_state_t state_q;
  logic [TILE_W-1:0]    grant_q;  // Tile being streamed
  logic [TILE_W-1:0]    last_q;   // Last tile served
  logic [TILE_W-1:0]    pick_idx;
  logic                 pick_found;

  // Next ready tile after the last one served
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int i = 1; i <= N_TILES; i++) begin
      if (!pick_found && line_ready_i[(int'(last_q) + i) % N_TILES]) begin
        pick_found = 1'b1;
        pick_idx   = TILE_W'((int'(last_q) + i) % N_TILES);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= mesh_pkg::SCAN;
      grant_q <= '0;
      last_q  <= TILE_W'(N_TILES - 1); // Tile 0 goes first
    end else begin
      case (state_q)
        mesh_pkg::SCAN: begin
          if (pick_found) begin
            grant_q <= pick_idx;
            state_q <= mesh_pkg::STREAM;
          end
        end
        mesh_pkg::STREAM: begin
          if (head_last_i[grant_q]) begin // Line end leaves the buffer now
            last_q  <= grant_q;
            state_q <= mesh_pkg::SCAN;
          end
        end
        default: state_q <= mesh_pkg::SCAN;
      endcase
    end
  end

  // Stream the granted head straight through
  always_comb begin
    pop_o = '0;
    if (state_q == mesh_pkg::STREAM) begin
      pop_o[grant_q] = 1'b1;
    end
  end

  assign con_valid_o = (state_q == mesh_pkg::STREAM);
  assign con_tile_o  = grant_q;
  assign con_char_o  = head_char_i[grant_q];
  assign con_last_o  = con_valid_o && head_last_i[grant_q];

  // Output tile, popped buffer and a pending line all agree
  a_grant_match : assert property (
    @(posedge clk) disable iff (rst_i)
    con_valid_o |-> (pop_o == (N_TILES'(1) << con_tile_o)) && line_ready_i[con_tile_o]
  ) else $error("console_arbiter: output tile differs from granted tile");

endmodule

`default_nettype wire

//--- console_capture.sv
`default_nettype none

// Per-tile console buffer, releases characters once a line is complete
module console_capture #(
  parameter int TILE_ID    = 0,
  parameter int LINE_DEPTH = 16
) (
  input  logic            clk,
  input  logic            rst_i,
  input  logic            wr_valid_i,
  input  mesh_pkg::addr_t wr_addr_i,
  input  mesh_pkg::char_t wr_data_i,
  input  logic            pop_i,        // Arbiter takes the head entry
  output logic            line_ready_o, // At least one whole line buffered
  output mesh_pkg::char_t head_char_o,
  output logic            head_last_o,
  output logic            overflow_o    // Sticky, a write was dropped
);

  localparam int PTR_W = (LINE_DEPTH > 1) ? $clog2(LINE_DEPTH) : 1;
  localparam int CNT_W = $clog2(LINE_DEPTH + 1);
  // This tile's own console address
  localparam mesh_pkg::addr_t MY_ADDR = mesh_pkg::STDIO_BASE + mesh_pkg::addr_t'(4 * TILE_ID);

  mesh_pkg::char_t  char_mem [LINE_DEPTH]; // Character storage
  logic             last_mem [LINE_DEPTH]; // Line-end mark per entry
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;               // Entries held
  logic [CNT_W-1:0] lines_q;               // Complete lines held

  logic hit;
  logic full;
  logic push;
  logic push_last;
  logic pop_last;

  assign hit       = wr_valid_i && (wr_addr_i == MY_ADDR);
  assign full      = (count_q == CNT_W'(LINE_DEPTH));
  assign push      = hit && !full;
  // Newline ends a line, so does the write that fills the buffer
  assign push_last = (wr_data_i == mesh_pkg::NEWLINE) || (count_q == CNT_W'(LINE_DEPTH - 1));
  assign pop_last  = pop_i && last_mem[rd_ptr_q];

  // Character and line-end storage
  always_ff @(posedge clk) begin
    if (push) begin
      char_mem[wr_ptr_q] <= wr_data_i;
      last_mem[wr_ptr_q] <= push_last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      lines_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(LINE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(LINE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop_i);
      lines_q <= lines_q + CNT_W'(push && push_last) - CNT_W'(pop_last);
      if (hit && full) begin
        overflow_o <= 1'b1; // Char lost
      end
    end
  end

  assign line_ready_o = (lines_q != '0);
  assign head_char_o  = char_mem[rd_ptr_q]; // Oldest entry
  assign head_last_o  = last_mem[rd_ptr_q];

  // Arbiter may only pop what is buffered
  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (rst_i)
    pop_i |-> (count_q != '0)
  ) else $error("console_capture %0d: pop on empty buffer", TILE_ID);

endmodule

`default_nettype wire

//--- eoc_tracker.sv
`default_nettype none

// Exit code collection, all-done flag and run-cycle counter
module eoc_tracker #(
  parameter int N_TILES = 4
) (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic [N_TILES-1:0]   wr_valid_i,
  input  mesh_pkg::addr_t      wr_addr_i [N_TILES],
  input  mesh_pkg::char_t      wr_data_i [N_TILES],
  output mesh_pkg::exit_code_t exit_codes_o [N_TILES],
  output logic                 all_done_o,
  output mesh_pkg::cycle_t     cycles_o
);

  logic [N_TILES-1:0] reported_q; // Tile has sent its exit code

  for (genvar t = 0; t < N_TILES; t++) begin : gen_tile
    logic exit_hit;

    // Only the first exit write of a tile counts
    assign exit_hit = wr_valid_i[t] && (wr_addr_i[t] == mesh_pkg::EXIT_ADDR) && !reported_q[t];

    always_ff @(posedge clk) begin
      if (rst_i) begin
        reported_q[t]   <= 1'b0;
        exit_codes_o[t] <= '0;
      end else if (exit_hit) begin
        reported_q[t]   <= 1'b1;
        exit_codes_o[t] <= mesh_pkg::exit_code_t'(wr_data_i[t]);
      end
    end
  end

  // High the cycle after the final report
  assign all_done_o = &reported_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cycles_o <= '0;
    end else if (!all_done_o) begin
      cycles_o <= cycles_o + 1'b1; // Frozen once everyone is done
    end
  end

endmodule

`default_nettype wire

//--- mesh_monitor.f
mesh_pkg.sv
sync_node.sv
sync_root.sv
console_capture.sv
console_arbiter.sv
eoc_tracker.sv
mesh_monitor_top.sv
tb_mesh_monitor.sv

//--- mesh_monitor_top.sv
`default_nettype none

// Mesh run monitor, barrier tree, console path and end-of-computation
module mesh_monitor_top #(
  parameter int N_TILES    = 4,
  parameter int LINE_DEPTH = 16
) (
  input  logic                  clk,
  input  logic                  rst_i,
  // Tile write buses
  input  logic [N_TILES-1:0]    wr_valid_i,
  input  mesh_pkg::addr_t       wr_addr_i [N_TILES],
  input  mesh_pkg::char_t       wr_data_i [N_TILES],
  // Barrier pairs
  input  logic [N_TILES-1:0]    sync_i,
  output logic [N_TILES-1:0]    wake_o,
  // Console output
  output logic                  con_valid_o,
  output logic [$clog2(N_TILES)-1:0] con_tile_o,
  output mesh_pkg::char_t       con_char_o,
  output logic                  con_last_o,
  // Status
  output logic [N_TILES-1:0]    overflow_o,
  output logic                  all_done_o,
  output mesh_pkg::exit_code_t  exit_codes_o [N_TILES],
  output mesh_pkg::cycle_t      cycles_o
);

  logic [1:0]            leaf_sync; // Leaf requests to the upper node
  logic [1:0]            leaf_wake;
  logic                  top_sync;  // Upper node to root
  logic                  root_wake;
  logic [N_TILES-1:0]    line_ready;
  mesh_pkg::char_t       head_char [N_TILES];
  logic [N_TILES-1:0]    head_last;
  logic [N_TILES-1:0]    pop;

  // Two leaves, two tiles each
  for (genvar l = 0; l < 2; l++) begin : gen_leaf
    sync_node u_leaf (
      .clk          (clk),
      .rst_i        (rst_i),
      .child_sync_i (sync_i[2*l+1:2*l]),
      .wake_i       (leaf_wake[l]),
      .sync_o       (leaf_sync[l]),
      .child_wake_o (wake_o[2*l+1:2*l])
    );
  end

  sync_node u_top_node (
    .clk          (clk),
    .rst_i        (rst_i),
    .child_sync_i (leaf_sync),
    .wake_i       (root_wake),
    .sync_o       (top_sync),
    .child_wake_o (leaf_wake)
  );

  sync_root u_root (
    .clk    (clk),
    .rst_i  (rst_i),
    .sync_i (top_sync),
    .wake_o (root_wake)
  );

  // One console buffer per tile
  for (genvar t = 0; t < N_TILES; t++) begin : gen_cap
    console_capture #(
      .TILE_ID    (t),
      .LINE_DEPTH (LINE_DEPTH)
    ) u_cap (
      .clk          (clk),
      .rst_i        (rst_i),
      .wr_valid_i   (wr_valid_i[t]),
      .wr_addr_i    (wr_addr_i[t]),
      .wr_data_i    (wr_data_i[t]),
      .pop_i        (pop[t]),
      .line_ready_o (line_ready[t]),
      .head_char_o  (head_char[t]),
      .head_last_o  (head_last[t]),
      .overflow_o   (overflow_o[t])
    );
  end

  console_arbiter #(
    .N_TILES (N_TILES)
  ) u_arb (
    .clk          (clk),
    .rst_i        (rst_i),
    .line_ready_i (line_ready),
    .head_char_i  (head_char),
    .head_last_i  (head_last),
    .pop_o        (pop),
    .con_valid_o  (con_valid_o),
    .con_tile_o   (con_tile_o),
    .con_char_o   (con_char_o),
    .con_last_o   (con_last_o)
  );

  eoc_tracker #(
    .N_TILES (N_TILES)
  ) u_eoc (
    .clk          (clk),
    .rst_i        (rst_i),
    .wr_valid_i   (wr_valid_i),
    .wr_addr_i    (wr_addr_i),
    .wr_data_i    (wr_data_i),
    .exit_codes_o (exit_codes_o),
    .all_done_o   (all_done_o),
    .cycles_o     (cycles_o)
  );

endmodule

`default_nettype wire

//--- mesh_pkg.sv
`default_nettype none

package mesh_pkg;

  // Bus and payload widths
  typedef logic [31:0] addr_t;      // Tile write address
  typedef logic [7:0]  char_t;      // Console char, low byte of a write
  typedef logic [7:0]  exit_code_t; // Exit code of one tile
  typedef logic [63:0] cycle_t;     // Run-cycle count

  // Memory-mapped run control addresses
  localparam addr_t EXIT_ADDR  = 32'hFFFF_0000; // Exit code, shared by all tiles
  localparam addr_t STDIO_BASE = 32'hFFFF_0004; // Tile 0 console, tile k at +4k

  localparam char_t NEWLINE = 8'd10; // ASCII line feed

  // Root responder of the barrier tree
  typedef enum logic [1:0] {
    IDLE,    // Waiting for the tree-wide arrival
    RESPOND, // Wake is being registered
    HOLD     // Wake visible, new request ignored
  } root_state_t;

  // Console line arbiter
  typedef enum logic {
    SCAN,   // Looking for the next ready tile
    STREAM  // Emitting one line from the granted tile
  } arb_state_t;

endpackage

`default_nettype wire

//--- sync_node.sv
`default_nettype none

// Barrier tree node, merges two children into one request
module sync_node (
  input  logic       clk,
  input  logic       rst_i,
  input  logic [1:0] child_sync_i, // One-cycle request per child
  input  logic       wake_i,       // Wake from the parent
  output logic       sync_o,       // Registered request to the parent
  output logic [1:0] child_wake_o  // Registered wake to both children
);

  logic [1:0] arrived_q; // One flag per child
  logic [1:0] arrived_d;

  // Flags including the requests of this cycle
  assign arrived_d = arrived_q | child_sync_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      arrived_q    <= '0;
      sync_o       <= 1'b0;
      child_wake_o <= '0;
    end else begin
      // Pulse only on the edge where the second child lands
      sync_o       <= (&arrived_d) & ~(&arrived_q);
      child_wake_o <= {2{wake_i}}; // Fan the wake out to both sides
      if (wake_i) begin
        arrived_q <= '0; // Barrier released, start over
      end else begin
        arrived_q <= arrived_d;
      end
    end
  end

  // A child has to wait for its wake before it may request again
  for (genvar c = 0; c < 2; c++) begin : gen_chk
    a_no_rerequest : assert property (
      @(posedge clk) disable iff (rst_i)
      child_sync_i[c] |-> !arrived_q[c]
    ) else $error("sync_node: child %0d requested twice before wake", c);
  end

endmodule

`default_nettype wire

//--- sync_root.sv
`default_nettype none

// Root responder, answers a tree-wide arrival with one wake pulse
module sync_root (
  input  logic clk,
  input  logic rst_i,
  input  logic sync_i, // Request from the top node
  output logic wake_o  // Registered wake pulse
);

  mesh_pkg::root_state_t state_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= mesh_pkg::IDLE;
      wake_o  <= 1'b0;
    end else begin
      wake_o <= (state_q == mesh_pkg::RESPOND); // One cycle after the request
      case (state_q)
        mesh_pkg::IDLE: begin
          if (sync_i) begin
            state_q <= mesh_pkg::RESPOND;
          end
        end
        mesh_pkg::RESPOND: state_q <= mesh_pkg::HOLD;
        mesh_pkg::HOLD:    state_q <= mesh_pkg::IDLE; // Request here is not taken
        default:           state_q <= mesh_pkg::IDLE;
      endcase
    end
  end

  // Wake is a single-cycle event for the whole tree
  a_wake_single : assert property (
    @(posedge clk) disable iff (rst_i)
    wake_o |=> !wake_o
  ) else $error("sync_root: wake held for two cycles");

endmodule

`default_nettype wire

//--- tb_mesh_monitor.sv
`default_nettype none

module tb_mesh_monitor;

  localparam int N_TILES    = 4;
  localparam int LINE_DEPTH = 8;
  localparam int WAIT_LIMIT = 200; // Cycles allowed per wait
  localparam int SYNC_LAT   = 5;   // Last arrival to wake

  // Row kinds
  localparam logic [1:0] K_SYNC  = 2'd0;
  localparam logic [1:0] K_WRITE = 2'd1;
  localparam logic [1:0] K_IDLE  = 2'd2;

  typedef struct packed {
    logic [1:0]      kind;
    logic [1:0]      tile;
    mesh_pkg::addr_t addr;
    mesh_pkg::char_t data; // Char, exit code or base idle gap
    logic [7:0]      expv; // Wake latency, or 1 if the write must take effect
  } row_t;

  logic                 clk = 1'b0;
  logic                 rst_i;
  logic [N_TILES-1:0]   wr_valid_i;
  mesh_pkg::addr_t      wr_addr_i [N_TILES];
  mesh_pkg::char_t      wr_data_i [N_TILES];
  logic [N_TILES-1:0]   sync_i;
  logic [N_TILES-1:0]   wake_o;
  logic                 con_valid_o;
  logic [1:0]           con_tile_o;
  mesh_pkg::char_t      con_char_o;
  logic                 con_last_o;
  logic [N_TILES-1:0]   overflow_o;
  logic                 all_done_o;
  mesh_pkg::exit_code_t exit_codes_o [N_TILES];
  mesh_pkg::cycle_t     cycles_o;

  row_t                 rows [$];           // Stimulus table
  logic [8:0]           exp_q [N_TILES][$]; // {last, char} still due per tile
  int                   line_len [N_TILES]; // Chars of the open line
  logic [N_TILES-1:0]   ovf_mask;
  mesh_pkg::exit_code_t exit_model [N_TILES];
  int                   n_reported;
  int                   value_errs;
  int                   con_errs;
  int                   timeouts;
  logic                 in_line;            // Console is mid line
  logic [1:0]           line_tile;

  mesh_monitor_top #(
    .N_TILES    (N_TILES),
    .LINE_DEPTH (LINE_DEPTH)
  ) dut (
    .clk          (clk),
    .rst_i        (rst_i),
    .wr_valid_i   (wr_valid_i),
    .wr_addr_i    (wr_addr_i),
    .wr_data_i    (wr_data_i),
    .sync_i       (sync_i),
    .wake_o       (wake_o),
    .con_valid_o  (con_valid_o),
    .con_tile_o   (con_tile_o),
    .con_char_o   (con_char_o),
    .con_last_o   (con_last_o),
    .overflow_o   (overflow_o),
    .all_done_o   (all_done_o),
    .exit_codes_o (exit_codes_o),
    .cycles_o     (cycles_o)
  );

  always #2 clk = ~clk; // Period 4

  function automatic mesh_pkg::addr_t console_addr(input int tile);
    return mesh_pkg::STDIO_BASE + 32'(4 * tile);
  endfunction

  task automatic value_error(input string msg);
    $display("** Error @%0t: %s", $time, msg);
    value_errs++;
  endtask

  task automatic end_run();
    $display("Errors: %0d value, %0d console, %0d timeout", value_errs, con_errs, timeouts);
    if (value_errs == 0 && con_errs == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic give_up(input string what);
    $display("Timeout while waiting for %s", what);
    timeouts++;
    end_run();
  endtask

  task automatic add_row(input logic [1:0] kind, input int tile, input mesh_pkg::addr_t addr,
                         input int data, input int expv);
    row_t r;
    r.kind = kind;
    r.tile = 2'(tile);
    r.addr = addr;
    r.data = 8'(data);
    r.expv = 8'(expv);
    rows.push_back(r);
  endtask

  // One char per tile per column, so lines of all tiles overlap in time
  task automatic add_interleaved(input string t0, input string t1, input string t2,
                                 input string t3);
    string text [N_TILES];
    string line;
    text[0] = t0;
    text[1] = t1;
    text[2] = t2;
    text[3] = t3;
    for (int col = 0; col < 6; col++) begin
      for (int t = 0; t < N_TILES; t++) begin
        line = text[t];
        if (col < line.len()) begin
          add_row(K_WRITE, t, console_addr(t), int'(line.getc(col)), 1);
        end
      end
      add_row(K_IDLE, 0, '0, 1, 0);
    end
  endtask

  task automatic build_table();
    add_row(K_SYNC, 0, '0, 0, SYNC_LAT);
    add_row(K_IDLE, 0, '0, 4, 0);
    add_row(K_SYNC, 0, '0, 0, SYNC_LAT);
    add_interleaved("ab\n", "cde\n", "f\n", "ghij\n");
    add_interleaved("wxyz\n", "1\n", "23\n", "456\n");
    add_row(K_IDLE, 0, '0, 30, 0);
    // Forced line on tile 2, then a ninth char into the full buffer
    for (int i = 0; i < LINE_DEPTH; i++) begin
      add_row(K_WRITE, 2, console_addr(2), int'("0") + i, 1);
    end
    add_row(K_WRITE, 2, console_addr(2), int'("X"), 0);
    add_row(K_IDLE, 0, '0, 30, 0);
    // Stray addresses, no effect anywhere
    add_row(K_WRITE, 1, console_addr(0), int'("s"), 0);
    add_row(K_WRITE, 3, 32'h0000_1000, int'("t"), 0);
    add_row(K_WRITE, 0, console_addr(N_TILES), int'("u"), 0);
    add_row(K_WRITE, 2, mesh_pkg::EXIT_ADDR - 32'd4, int'("v"), 0);
    add_interleaved("z\n", "", "ok\n", "y\n");
    add_row(K_IDLE, 0, '0, 10, 0);
    add_row(K_WRITE, 3, mesh_pkg::EXIT_ADDR, 8'h03, 1);
    add_row(K_IDLE, 0, '0, 3, 0);
    add_row(K_WRITE, 0, mesh_pkg::EXIT_ADDR, 8'h2a, 1);
    add_row(K_WRITE, 0, mesh_pkg::EXIT_ADDR, 8'hee, 0); // Only first one counts
    add_row(K_WRITE, 2, mesh_pkg::EXIT_ADDR, 8'h7f, 1);
    add_row(K_IDLE, 0, '0, 3, 0);
    add_row(K_WRITE, 1, mesh_pkg::EXIT_ADDR, 8'h01, 1); // Completes the set
  endtask

  task automatic check_reset_state();
    assert (wake_o == '0 && !con_valid_o && !con_last_o && overflow_o == '0 && !all_done_o)
      else value_error("status or strobe active right after reset");
    assert (cycles_o == '0) else value_error($sformatf("cycles_o is %0d", cycles_o));
    for (int t = 0; t < N_TILES; t++) begin
      assert (exit_codes_o[t] == '0)
        else value_error($sformatf("exit code %0d is %h", t, exit_codes_o[t]));
    end
  endtask

  task automatic run_barrier(input int latency);
    int order [N_TILES];
    int pick;
    int tmp;
    int gap;
    int waited;
    for (int i = 0; i < N_TILES; i++) begin
      order[i] = i;
    end
    for (int i = N_TILES - 1; i > 0; i--) begin // Shuffle the arrival order
      pick = int'($urandom % (i + 1));
      tmp = order[i];
      order[i] = order[pick];
      order[pick] = tmp;
    end
    for (int k = 0; k < N_TILES; k++) begin
      @(posedge clk);
      wr_valid_i <= '0;
      sync_i     <= N_TILES'(1) << order[k];
      gap = (k == N_TILES - 1) ? 0 : int'($urandom % 3);
      repeat (gap) begin
        @(posedge clk);
        sync_i <= '0;
        @(negedge clk);
        assert (wake_o == '0) else value_error("wake before all tiles arrived");
      end
    end
    @(posedge clk); // Last request sampled here
    sync_i <= '0;
    waited = 0;
    @(negedge clk);
    while (wake_o == '0 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
      @(negedge clk);
    end
    if (wake_o == '0) begin
      give_up("wake_o");
    end
    assert (wake_o == '1 && waited == latency)
      else value_error($sformatf("wake %b after %0d cycles", wake_o, waited));
    @(negedge clk);
    assert (wake_o == '0) else value_error("wake longer than one cycle");
  endtask

  task automatic apply_write(input row_t r);
    int   t;
    logic last;
    t = int'(r.tile);
    @(posedge clk);
    sync_i        <= '0;
    wr_valid_i    <= N_TILES'(1) << t;
    wr_addr_i[t]  <= r.addr;
    wr_data_i[t]  <= r.data;
    if (r.addr == console_addr(t)) begin
      if (r.expv != 0) begin
        last = (r.data == mesh_pkg::NEWLINE) || (line_len[t] + 1 == LINE_DEPTH);
        exp_q[t].push_back({last, r.data});
        line_len[t] = last ? 0 : line_len[t] + 1;
      end else begin
        ovf_mask[t] = 1'b1; // Own write into a full buffer
      end
    end else if (r.addr == mesh_pkg::EXIT_ADDR) begin
      @(negedge clk);
      assert (n_reported == N_TILES || !all_done_o)
        else value_error($sformatf("all_done_o with %0d exit codes", n_reported));
      if (r.expv != 0) begin
        exit_model[t] = r.data;
        n_reported++;
      end
    end
  endtask

  // Console checker, sampled away from the clock edge
  always @(negedge clk) begin : con_check
    logic [8:0] want;
    if (!rst_i && con_valid_o) begin
      assert (!in_line || con_tile_o == line_tile) else begin
        $display("** Error @%0t: tile %0d inside a line of tile %0d", $time, con_tile_o,
                 line_tile);
        con_errs++;
      end
      assert (exp_q[con_tile_o].size() != 0) else begin
        $display("** Error @%0t: unexpected char %h from tile %0d", $time, con_char_o,
                 con_tile_o);
        con_errs++;
      end
      if (exp_q[con_tile_o].size() != 0) begin
        want = exp_q[con_tile_o].pop_front();
        assert (con_char_o == want[7:0] && con_last_o == want[8]) else begin
          $display("** Error @%0t: tile %0d char %h last %b, want %h last %b", $time,
                   con_tile_o, con_char_o, con_last_o, want[7:0], want[8]);
          con_errs++;
        end
      end
      in_line   = !con_last_o;
      line_tile = con_tile_o;
    end
  end

  function automatic int pending_chars();
    int n;
    n = 0;
    for (int t = 0; t < N_TILES; t++) begin
      n += exp_q[t].size();
    end
    return n;
  endfunction

  initial begin
    row_t             r;
    int               gap;
    int               waited;
    mesh_pkg::cycle_t frozen;
    void'($urandom(79798));
    rst_i      = 1'b1;
    wr_valid_i = '0;
    sync_i     = '0;
    ovf_mask   = '0;
    n_reported = 0;
    value_errs = 0;
    con_errs   = 0;
    timeouts   = 0;
    in_line    = 1'b0;
    line_tile  = '0;
    for (int t = 0; t < N_TILES; t++) begin
      wr_addr_i[t]  = '0;
      wr_data_i[t]  = '0;
      line_len[t]   = 0;
      exit_model[t] = '0;
    end
    build_table();
    repeat (8) @(posedge clk);
    rst_i <= 1'b0;
    @(negedge clk);
    check_reset_state();

    foreach (rows[i]) begin
      r = rows[i];
      case (r.kind)
        K_SYNC:  run_barrier(int'(r.expv));
        K_WRITE: apply_write(r);
        default: begin
          gap = int'(r.data) + int'($urandom % 4);
          repeat (gap) begin
            @(posedge clk);
            wr_valid_i <= '0;
            sync_i     <= '0;
          end
        end
      endcase
    end

    // Last row was the completing exit write
    waited = 0;
    @(posedge clk);
    wr_valid_i <= '0;
    do begin
      @(negedge clk);
      waited++;
    end while (!all_done_o && waited < WAIT_LIMIT);
    if (!all_done_o) begin
      give_up("all_done_o");
    end
    assert (waited == 1) else value_error($sformatf("all_done_o %0d cycles late", waited));
    for (int t = 0; t < N_TILES; t++) begin
      assert (exit_codes_o[t] == exit_model[t])
        else value_error($sformatf("exit code %0d is %h, want %h", t, exit_codes_o[t],
                                   exit_model[t]));
    end
    frozen = cycles_o;
    assert (frozen != '0) else value_error("cycles_o never counted");
    repeat (10) begin // Counter must hold once done
      @(negedge clk);
      assert (cycles_o == frozen)
        else value_error($sformatf("cycles_o moved from %0d to %0d", frozen, cycles_o));
    end

    waited = 0;
    while ((pending_chars() != 0 || con_valid_o) && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (pending_chars() != 0 || con_valid_o) begin
      give_up("console drain");
    end
    assert (!in_line) else value_error("console stopped inside a line");
    assert (overflow_o == ovf_mask)
      else value_error($sformatf("overflow_o %b, want %b", overflow_o, ovf_mask));
    end_run();
  end

endmodule

`default_nettype wire
